// File: verilog/arb_defines.svh
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// ==========================================================
// pixel array geometry
// ==========================================================

`define ARB_ROWS        8   // pixel rows.
`define ARB_COLS        8   // pixel columns.

`define ARB_GRP_ROWS    2   // rows per group.
`define ARB_GRP_COLS    2   // columns per group.

`define ARB_NUM_GROUPS  16  // (8/2) * (8/2).

// ==========================================================
// address widths
// ==========================================================

`define ARB_LOC_W       1   // x or y inside a group.
`define ARB_ADD_W       3   // x or y across the array.

`endif

// File: verilog/arb_pkg.sv
`default_nettype none

`include "arb_defines.svh"

package arb_pkg;

   // index of one 2x2 group, row major over the group grid.
   typedef logic [$clog2(`ARB_NUM_GROUPS)-1:0] grp_idx_t;

   // global pixel coordinates, y in the upper bits.
   typedef struct packed {
      logic [`ARB_ADD_W-1:0] y;
      logic [`ARB_ADD_W-1:0] x;
   } pix_coord_t;

   // address event word.
   // the flat view is row * 8 + column, a frame memory address.
   typedef union packed {
      pix_coord_t              coord;
      logic [2*`ARB_ADD_W-1:0] flat;
   } pix_event_t;

endpackage

`default_nettype wire

// File: verilog/pixel_level.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module pixel_level (
   input  logic                                       clk_i,
   input  logic                                       reset_i,
   input  logic                                       enable_i,      // group holds the token.
   input  logic                                       grp_enable_i,  // readout enable.
   input  logic [`ARB_GRP_ROWS-1:0][`ARB_GRP_COLS-1:0] req_i,
   output logic                                       req_o,
   output logic [`ARB_GRP_ROWS-1:0][`ARB_GRP_COLS-1:0] gnt_o,
   output logic [`ARB_LOC_W-1:0]                      x_add_o,
   output logic [`ARB_LOC_W-1:0]                      y_add_o,
   output logic                                       active_o,
   output logic                                       grp_release_o
);

   localparam int NUM_PIX = `ARB_GRP_ROWS * `ARB_GRP_COLS;
   localparam int PTR_W   = $clog2(NUM_PIX);

   logic [NUM_PIX-1:0] req_vec;
   logic [NUM_PIX-1:0] gnt_q;
   logic [NUM_PIX-1:0] gnt_d;
   logic [PTR_W-1:0]   ptr_q;
   logic [PTR_W-1:0]   next_idx;
   logic               next_found;
   logic               grant_start;

   assign req_vec  = req_i;      // local index is row * cols + col.
   assign req_o    = |req_vec;
   assign gnt_o    = gnt_q;
   assign active_o = |gnt_q;

   // nothing left to serve besides the pixel granted right now
   assign grp_release_o = enable_i && !(|(req_vec & ~gnt_q));

   assign grant_start = enable_i && grp_enable_i && req_o && !grp_release_o;

   // ==========================================================
   // round-robin search from just after the pointer
   // ==========================================================

   always_comb begin
      next_idx   = ptr_q;
      next_found = 1'b0;
      for (int i = 1; i <= NUM_PIX; i++) begin
         if (!next_found && req_vec[PTR_W'(int'(ptr_q) + i)]) begin
            next_found = 1'b1;
            next_idx   = PTR_W'(int'(ptr_q) + i);  // wraps at the group size.
         end
      end
   end

   assign gnt_d = grant_start ? (NUM_PIX'(1) << next_idx) : '0;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         gnt_q <= '0;
         ptr_q <= '0;
      end else begin
         gnt_q <= gnt_d;             // one cycle per grant.
         if (grant_start) begin
            ptr_q <= next_idx;
         end
      end
   end

   // local address of the granted pixel.
   always_comb begin
      x_add_o = '0;
      y_add_o = '0;
      for (int i = 0; i < NUM_PIX; i++) begin
         if (gnt_q[i]) begin
            x_add_o = `ARB_LOC_W'(i % `ARB_GRP_COLS);
            y_add_o = `ARB_LOC_W'(i / `ARB_GRP_COLS);
         end
      end
   end

   a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(gnt_q));

endmodule

`default_nettype wire

// File: verilog/pixel_groups.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module pixel_groups (
   input  logic                                       clk_i,
   input  logic                                       reset_i,
   input  logic [`ARB_ROWS-1:0][`ARB_COLS-1:0]         req_i,
   input  logic [`ARB_NUM_GROUPS-1:0]                 grp_sel_i,
   input  logic                                       grp_enable_i,
   output logic [`ARB_NUM_GROUPS-1:0]                 grp_req_o,
   output logic [`ARB_ROWS-1:0][`ARB_COLS-1:0]         gnt_out_o,
   output logic [`ARB_GRP_ROWS-1:0][`ARB_GRP_COLS-1:0] gnt_o,
   output logic [`ARB_LOC_W-1:0]                      x_add_o,
   output logic [`ARB_LOC_W-1:0]                      y_add_o,
   output logic                                       active_o,
   output logic                                       grp_release_o
);

   import arb_pkg::*;

   localparam int NUM_GRP     = `ARB_NUM_GROUPS;
   localparam int GRP_PER_ROW = `ARB_COLS / `ARB_GRP_COLS;

   logic [NUM_GRP-1:0][`ARB_GRP_ROWS-1:0][`ARB_GRP_COLS-1:0] set_group;
   logic [NUM_GRP-1:0][`ARB_GRP_ROWS-1:0][`ARB_GRP_COLS-1:0] gnt_temp;
   logic [NUM_GRP-1:0][`ARB_LOC_W-1:0]                      x_add_temp;
   logic [NUM_GRP-1:0][`ARB_LOC_W-1:0]                      y_add_temp;
   logic [NUM_GRP-1:0]                                      active_temp;
   logic [NUM_GRP-1:0]                                      release_temp;

   // top left pixel of a group's tile.
   function automatic int tile_row(grp_idx_t grp);
      return (int'(grp) / GRP_PER_ROW) * `ARB_GRP_ROWS;
   endfunction

   function automatic int tile_col(grp_idx_t grp);
      return (int'(grp) % GRP_PER_ROW) * `ARB_GRP_COLS;
   endfunction

   // ==========================================================
   // tiling of requests and grants
   // ==========================================================

   always_comb begin
      for (int g = 0; g < NUM_GRP; g++) begin
         for (int r = 0; r < `ARB_GRP_ROWS; r++) begin
            for (int c = 0; c < `ARB_GRP_COLS; c++) begin
               set_group[g][r][c] =
                  req_i[tile_row(grp_idx_t'(g)) + r][tile_col(grp_idx_t'(g)) + c];
               gnt_out_o[tile_row(grp_idx_t'(g)) + r][tile_col(grp_idx_t'(g)) + c] =
                  gnt_temp[g][r][c];
            end
         end
      end
   end

   for (genvar g = 0; g < NUM_GRP; g++) begin : g_group
      pixel_level i_pixel_level (
         .clk_i         (clk_i),
         .reset_i       (reset_i),
         .enable_i      (grp_sel_i[g]),
         .grp_enable_i  (grp_enable_i),
         .req_i         (set_group[g]),
         .req_o         (grp_req_o[g]),
         .gnt_o         (gnt_temp[g]),
         .x_add_o       (x_add_temp[g]),
         .y_add_o       (y_add_temp[g]),
         .active_o      (active_temp[g]),
         .grp_release_o (release_temp[g])
      );
   end

   assign active_o = |active_temp;

   // forward the group that holds the token.
   always_comb begin
      gnt_o         = '0;
      x_add_o       = '0;
      y_add_o       = '0;
      grp_release_o = 1'b0;
      for (int g = 0; g < NUM_GRP; g++) begin
         if (grp_sel_i[g]) begin
            gnt_o         = gnt_temp[g];
            x_add_o       = x_add_temp[g];
            y_add_o       = y_add_temp[g];
            grp_release_o = release_temp[g];
         end
      end
   end

   a_one_active: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(active_temp));

endmodule

`default_nettype wire

// File: verilog/group_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module group_arbiter (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic [`ARB_NUM_GROUPS-1:0] grp_req_i,
   input  logic                       grp_release_i,
   output logic [`ARB_NUM_GROUPS-1:0] grp_sel_o,
   output arb_pkg::grp_idx_t          grp_idx_o
);

   import arb_pkg::*;

   localparam int NUM_GRP = `ARB_NUM_GROUPS;

   logic [NUM_GRP-1:0] sel_q;
   logic [NUM_GRP-1:0] sel_d;
   grp_idx_t           idx_q;
   grp_idx_t           idx_d;
   grp_idx_t           base;
   logic               found;

   // ==========================================================
   // token hand-off
   // ==========================================================

   always_comb begin
      sel_d = sel_q;
      idx_d = idx_q;
      found = 1'b0;
      // the pointer itself may win when idle and goes last after a release
      base  = (sel_q == '0) ? idx_q : grp_idx_t'(idx_q + 1'b1);
      if ((sel_q == '0) || grp_release_i) begin
         sel_d = '0;                 // no requester leaves the token idle.
         for (int i = 0; i < NUM_GRP; i++) begin
            if (!found && grp_req_i[grp_idx_t'(int'(base) + i)]) begin
               found = 1'b1;
               idx_d = grp_idx_t'(int'(base) + i);
               sel_d[grp_idx_t'(int'(base) + i)] = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sel_q <= '0;
         idx_q <= '0;                // group 0 first after reset.
      end else begin
         sel_q <= sel_d;
         idx_q <= idx_d;
      end
   end

   assign grp_sel_o = sel_q;
   assign grp_idx_o = idx_q;

   a_sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(sel_q));

endmodule

`default_nettype wire

// File: verilog/event_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module event_encoder (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  active_i,
   input  arb_pkg::grp_idx_t     grp_idx_i,
   input  logic [`ARB_LOC_W-1:0] x_add_i,
   input  logic [`ARB_LOC_W-1:0] y_add_i,
   output logic                  event_valid_o,
   output arb_pkg::pix_event_t   event_o
);

   import arb_pkg::*;

   localparam int GRP_PER_ROW = `ARB_COLS / `ARB_GRP_COLS;

   pix_event_t event_d;
   pix_event_t event_q;
   logic       valid_q;

   // group origin plus local offset.
   always_comb begin
      event_d.coord.y = `ARB_ADD_W'((int'(grp_idx_i) / GRP_PER_ROW) * `ARB_GRP_ROWS
                                    + int'(y_add_i));
      event_d.coord.x = `ARB_ADD_W'((int'(grp_idx_i) % GRP_PER_ROW) * `ARB_GRP_COLS
                                    + int'(x_add_i));
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= active_i;        // one cycle after the grant.
      end
   end

   always_ff @(posedge clk_i) begin
      event_q <= event_d;
   end

   assign event_valid_o = valid_q;
   assign event_o       = event_q;

endmodule

`default_nettype wire

// File: verilog/pixel_arbiter_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module pixel_arbiter_top (
   input  logic                               clk_i,
   input  logic                               reset_i,
   input  logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] req_i,
   input  logic                               readout_en_i,
   output logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] gnt_o,
   output logic                               event_valid_o,
   output arb_pkg::pix_event_t                event_o,
   output logic                               busy_o
);

   import arb_pkg::*;

   logic [`ARB_NUM_GROUPS-1:0]                 grp_req;
   logic [`ARB_NUM_GROUPS-1:0]                 grp_sel;
   grp_idx_t                                   grp_idx;
   logic [`ARB_GRP_ROWS-1:0][`ARB_GRP_COLS-1:0] grp_gnt;   // grant of the token holder.
   logic [`ARB_LOC_W-1:0]                      loc_x;
   logic [`ARB_LOC_W-1:0]                      loc_y;
   logic                                       grp_release;
   logic                                       active;

   pixel_groups i_pixel_groups (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .req_i         (req_i),
      .grp_sel_i     (grp_sel),
      .grp_enable_i  (readout_en_i),
      .grp_req_o     (grp_req),
      .gnt_out_o     (gnt_o),
      .gnt_o         (grp_gnt),
      .x_add_o       (loc_x),
      .y_add_o       (loc_y),
      .active_o      (active),
      .grp_release_o (grp_release)
   );

   group_arbiter i_group_arbiter (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .grp_req_i     (grp_req),
      .grp_release_i (grp_release),
      .grp_sel_o     (grp_sel),
      .grp_idx_o     (grp_idx)
   );

   event_encoder i_event_encoder (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .active_i      (|grp_gnt),
      .grp_idx_i     (grp_idx),
      .x_add_i       (loc_x),
      .y_add_i       (loc_y),
      .event_valid_o (event_valid_o),
      .event_o       (event_o)
   );

   assign busy_o = active;

endmodule

`default_nettype wire

// File: sim/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ==========================================================
// compare tasks
// ==========================================================

task automatic check_bit(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
   end
endtask

task automatic check_event(input string name, input pix_event_t got, input pix_event_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=(y%0d,x%0d) exp=(y%0d,x%0d)", $time, name,
               got.coord.y, got.coord.x, exp.coord.y, exp.coord.x);
   end
endtask

task automatic check_gnt(input string name, input pix_mat_t got, input pix_mat_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
   end
endtask

// ==========================================================
// stimulus and bounded waits
// ==========================================================

// only idle pixels are raised, so each raise is worth one event.
task automatic raise_requests(input pix_mat_t mask, output pix_mat_t applied);
   @(posedge clk);
   applied    = mask & ~req;
   raise_mask = applied;
   @(posedge clk);
   raise_mask = '0;
endtask

task automatic book_requests(input pix_mat_t applied);
   for (int r = 0; r < `ARB_ROWS; r++) begin
      for (int c = 0; c < `ARB_COLS; c++) begin
         if (applied[r][c]) begin
            pend_cnt[r * `ARB_COLS + c]++;
            pending++;
         end
      end
   end
endtask

task automatic wait_event(output pix_event_t ev, output bit ok);
   ok = 1'b0;
   for (int i = 0; i < EVT_TIMEOUT && !ok; i++) begin
      @(posedge clk);
      if (evt_q.size() > 0) begin
         ev = evt_q.pop_front();
         ok = 1'b1;
      end
   end
   if (!ok) begin
      timeouts++;
      $display("t=%0t no address event arrived within %0d cycles", $time, EVT_TIMEOUT);
   end
endtask

task automatic wait_idle();
   bit idle;
   idle = 1'b0;
   for (int i = 0; i < IDLE_TIMEOUT && !idle; i++) begin
      @(negedge clk);
      idle = (req == '0) && !busy && !event_valid;
   end
   if (!idle) begin
      timeouts++;
      $display("t=%0t readout did not go idle within %0d cycles", $time, IDLE_TIMEOUT);
   end
endtask

task automatic check_no_extra();
   if (evt_q.size() != 0) begin
      sb_errors++;
      $display("t=%0t %0d address events arrived that no request asked for", $time,
               evt_q.size());
      evt_q.delete();
   end
endtask

// scoreboard by flat pixel index.
task automatic collect_events();
   pix_event_t ev;
   bit         ok;
   ok = 1'b1;
   while (pending > 0 && ok) begin
      wait_event(ev, ok);
      if (ok && pend_cnt[ev.flat] == 0) begin
         sb_errors++;
         $display("t=%0t event for pixel %0d, which has no open request", $time, ev.flat);
      end else if (ok) begin
         pend_cnt[ev.flat]--;
         pending--;
      end
   end
   if (pending != 0) begin
      sb_errors++;
      $display("t=%0t %0d requested pixels were never served", $time, pending);
      pending  = 0;
      pend_cnt = '{default: 0};
   end
   wait_idle();
   check_no_extra();
endtask

`endif

// File: sim/tb_pixel_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module tb_pixel_arbiter;

   import arb_pkg::*;

   typedef logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] pix_mat_t;

   localparam int EVT_TIMEOUT  = 200;   // cycles allowed per event.
   localparam int IDLE_TIMEOUT = 400;
   localparam int GRP_PER_ROW  = `ARB_COLS / `ARB_GRP_COLS;

   logic       clk;
   logic       reset;
   logic       readout_en;
   pix_mat_t   req;
   pix_mat_t   gnt;
   logic       event_valid;
   pix_event_t evt;
   logic       busy;

   pix_mat_t   raise_mask;          // pixels to raise at the next falling edge.
   pix_mat_t   prev_gnt;
   pix_event_t evt_q[$];
   int         pend_cnt[`ARB_ROWS*`ARB_COLS];
   int         pending;
   int         checks;
   int         errors;
   int         timeouts;
   int         sb_errors;

   pixel_arbiter_top i_dut (
      .clk_i         (clk),
      .reset_i       (reset),
      .req_i         (req),
      .readout_en_i  (readout_en),
      .gnt_o         (gnt),
      .event_valid_o (event_valid),
      .event_o       (evt),
      .busy_o        (busy)
   );

   `include "tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // a pixel drops its request on the falling edge of its grant cycle
   initial begin
      req <= '0;
      forever begin
         @(negedge clk);
         if (reset) begin
            req <= '0;
         end else begin
            req <= (req & ~gnt) | raise_mask;
         end
      end
   end

   // ==========================================================
   // event monitor
   // ==========================================================

   always @(negedge clk) begin
      pix_event_t exp_ev;
      if (!reset) begin
         check_bit("busy_o", busy, |gnt);
         if (event_valid) begin
            check_bit("gnt_o one-hot before event", $onehot(prev_gnt), 1'b1);
            exp_ev = '0;
            for (int r = 0; r < `ARB_ROWS; r++) begin
               for (int c = 0; c < `ARB_COLS; c++) begin
                  if (prev_gnt[r][c]) begin
                     exp_ev.coord.y = `ARB_ADD_W'(r);
                     exp_ev.coord.x = `ARB_ADD_W'(c);
                  end
               end
            end
            check_event("event_o", evt, exp_ev);
            evt_q.push_back(evt);
         end else begin
            check_bit("event_valid_o after grant", event_valid, |prev_gnt);
         end
      end
      prev_gnt = gnt;
   end

   task automatic apply_reset();
      reset <= 1'b1;
      for (int i = 0; i < 16; i++) begin
         @(negedge clk);
         check_gnt("gnt_o in reset", gnt, '0);
         check_bit("event_valid_o in reset", event_valid, 1'b0);
         check_bit("busy_o in reset", busy, 1'b0);
      end
      reset <= 1'b0;
      repeat (4) begin
         @(negedge clk);
         check_gnt("gnt_o after reset", gnt, '0);
         check_bit("event_valid_o after reset", event_valid, 1'b0);
         check_bit("busy_o after reset", busy, 1'b0);
      end
      evt_q.delete();
   endtask

   // groups in ascending order, local pixels 1, 2, 3, 0 with the pointer at 0.
   task automatic test_order_after_reset();
      pix_mat_t   applied;
      pix_event_t ev;
      pix_event_t exp_ev;
      int         loc;
      bit         ok;
      raise_requests('1, applied);
      for (int g = 0; g < `ARB_NUM_GROUPS; g++) begin
         for (int k = 1; k <= `ARB_GRP_ROWS * `ARB_GRP_COLS; k++) begin
            loc = k % (`ARB_GRP_ROWS * `ARB_GRP_COLS);
            exp_ev.coord.y = `ARB_ADD_W'((g / GRP_PER_ROW) * `ARB_GRP_ROWS + loc / `ARB_GRP_COLS);
            exp_ev.coord.x = `ARB_ADD_W'((g % GRP_PER_ROW) * `ARB_GRP_COLS + loc % `ARB_GRP_COLS);
            wait_event(ev, ok);
            if (ok) begin
               check_event("event_o in order", ev, exp_ev);
            end
         end
      end
      wait_idle();
      check_no_extra();
   endtask

   task automatic test_single_pixel();
      pix_mat_t   mask;
      pix_mat_t   applied;
      pix_event_t ev;
      pix_event_t exp_ev;
      int         r;
      int         c;
      bit         ok;
      r          = $urandom_range(`ARB_ROWS - 1);
      c          = $urandom_range(`ARB_COLS - 1);
      mask       = '0;
      mask[r][c] = 1'b1;
      raise_requests(mask, applied);
      wait_event(ev, ok);
      if (ok) begin
         exp_ev.coord.y = `ARB_ADD_W'(r);
         exp_ev.coord.x = `ARB_ADD_W'(c);
         check_event("event_o coord", ev, exp_ev);
         exp_ev.flat = (2*`ARB_ADD_W)'(r * `ARB_COLS + c);  // frame memory address.
         check_event("event_o flat", ev, exp_ev);
      end
      wait_idle();
      check_no_extra();
   endtask

   // two overlapping waves per round.
   task automatic test_random_waves();
      pix_mat_t applied;
      for (int w = 0; w < 4; w++) begin
         raise_requests({$urandom, $urandom} & {$urandom, $urandom}, applied);
         book_requests(applied);
         raise_requests({$urandom, $urandom} & {$urandom, $urandom}, applied);
         book_requests(applied);
         collect_events();
      end
   endtask

   task automatic test_readout_enable();
      pix_mat_t applied;
      @(negedge clk);
      readout_en <= 1'b0;
      raise_requests({$urandom, $urandom}, applied);
      book_requests(applied);
      for (int i = 0; i < 40; i++) begin
         @(negedge clk);
         check_bit("event_valid_o while readout off", event_valid, 1'b0);
         check_gnt("gnt_o while readout off", gnt, '0);
      end
      readout_en <= 1'b1;
      collect_events();
   endtask

   initial begin
      void'($urandom(32'h993c));
      reset      <= 1'b1;
      readout_en <= 1'b1;
      raise_mask  = '0;
      apply_reset();
      test_order_after_reset();
      repeat (4) test_single_pixel();
      test_random_waves();
      test_readout_enable();
      $display("closing report: %0d checks, %0d mismatches, %0d timeouts, %0d scoreboard errors",
               checks, errors, timeouts, sb_errors);
      if (errors + timeouts + sb_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
+incdir+sim
verilog/arb_pkg.sv
verilog/pixel_level.sv
verilog/pixel_groups.sv
verilog/group_arbiter.sv
verilog/event_encoder.sv
verilog/pixel_arbiter_top.sv
sim/tb_pixel_arbiter.sv

// File: Makefile
VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_pixel_arbiter
RTL_TOP    ?= pixel_arbiter_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --assert -Wno-fatal

RTL_SRCS := $(shell grep '^verilog/' $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+verilog --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^TB PASSED$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
